//--- rv_trace.f
source/rv_trace_pkg.sv
source/trace_capture.sv
source/instr_classify.sv
source/trace_record_pack.sv
source/rv_trace_top.sv
test/rv_trace_checker.sv
test/rv_trace_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= rv_trace_tb
FILELIST  ?= rv_trace.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

# the run passes only if the log holds the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/rv_trace_tb.sv
`timescale 1ns/1ps
// assumes the fixed three-cycle latency and a record consumer without back-pressure
module rv_trace_tb import rv_trace_pkg::*; ();

  localparam int NUM_ROWS   = 24;
  localparam int CLK_PERIOD = 8;

  // flags hold rd_we, rs1_en, rs2_en, mem_en, mem_we from msb down
  typedef struct packed {
    word_t        instr;
    reg_addr_t    ex_reg_addr;
    logic [3:0]   gap;
    instr_class_e iclass;
    word_t        imm;
    logic [4:0]   flags;
  } row_t;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       fetch_enable_i;
  logic       valid_i;
  word_t      pc_i;
  word_t      instr_i;
  word_t      rs1_value_i;
  word_t      rs2_value_i;
  reg_addr_t  ex_reg_addr_i;
  word_t      ex_reg_wdata_i;
  word_t      ex_data_addr_i;
  word_t      ex_data_wdata_i;
  word_t      ex_data_rdata_i;
  logic       trace_valid_o;
  trace_rec_t trace_rec_o;
  logic       exp_valid;
  trace_rec_t exp_rec;
  int         mismatch_cnt;
  int         unexpected_cnt;
  int         pending_cnt;
  row_t       rows [NUM_ROWS];
  word_t      lcg_state = 32'h824ec225;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic fill_table();
    rows[0]  = '{32'h0000_0013, 5'd0,  4'd0, CLS_NOP,     32'h0000_0000, 5'b00000};
    rows[1]  = '{32'hfff3_0293, 5'd5,  4'd1, CLS_OPIMM,   32'hffff_ffff, 5'b11000};
    rows[2]  = '{32'h0010_0013, 5'd0,  4'd0, CLS_OPIMM,   32'h0000_0001, 5'b00000};
    rows[3]  = '{32'h0033_1293, 5'd5,  4'd0, CLS_OPIMM,   32'h0000_0003, 5'b11000};
    // writeback address differs from rd
    rows[4]  = '{32'h4043_5293, 5'd6,  4'd2, CLS_OPIMM,   32'h0000_0404, 5'b01000};
    rows[5]  = '{32'habcd_e2b7, 5'd5,  4'd0, CLS_LUI,     32'habcd_e000, 5'b10000};
    rows[6]  = '{32'h1234_5297, 5'd5,  4'd0, CLS_AUIPC,   32'h1234_5000, 5'b10000};
    rows[7]  = '{32'hff9f_f0ef, 5'd1,  4'd3, CLS_JAL,     32'hffff_fff8, 5'b10000};
    rows[8]  = '{32'h0043_00e7, 5'd1,  4'd0, CLS_JALR,    32'h0000_0004, 5'b11000};
    rows[9]  = '{32'hfe73_08e3, 5'd17, 4'd0, CLS_BRANCH,  32'hffff_fff0, 5'b01100};
    rows[10] = '{32'h0073_2063, 5'd0,  4'd1, CLS_INVALID, 32'h0000_0000, 5'b00000};
    rows[11] = '{32'h0083_2283, 5'd5,  4'd0, CLS_LOAD,    32'h0000_0008, 5'b11010};
    rows[12] = '{32'hffc3_4283, 5'd5,  4'd0, CLS_LOAD,    32'hffff_fffc, 5'b11010};
    rows[13] = '{32'h0003_3283, 5'd5,  4'd2, CLS_INVALID, 32'h0000_0000, 5'b00000};
    rows[14] = '{32'h0073_2623, 5'd12, 4'd0, CLS_STORE,   32'h0000_000c, 5'b01111};
    rows[15] = '{32'hfe73_1f23, 5'd30, 4'd0, CLS_STORE,   32'hffff_fffe, 5'b01111};
    rows[16] = '{32'h0073_3023, 5'd0,  4'd1, CLS_INVALID, 32'h0000_0000, 5'b00000};
    rows[17] = '{32'h0073_02b3, 5'd5,  4'd0, CLS_OP,      32'h0000_0000, 5'b11100};
    rows[18] = '{32'h4003_02b3, 5'd5,  4'd0, CLS_OP,      32'h0000_0000, 5'b11000};
    rows[19] = '{32'h0273_02b3, 5'd4,  4'd0, CLS_MULDIV,  32'h0000_0000, 5'b01100};
    rows[20] = '{32'h3003_12f3, 5'd5,  4'd1, CLS_CSR_REG, 32'h0000_0300, 5'b11000};
    rows[21] = '{32'h3402_e2f3, 5'd5,  4'd0, CLS_CSR_IMM, 32'h0000_0340, 5'b10000};
    rows[22] = '{32'hf143_32f3, 5'd5,  4'd0, CLS_CSR_REG, 32'h0000_0f14, 5'b11000};
    rows[23] = '{32'h0000_0073, 5'd0,  4'd0, CLS_SYSTEM,  32'h0000_0000, 5'b00000};
  endtask

  task automatic apply_row(input int idx);
    row_t       r;
    trace_rec_t e;
    r               = rows[idx];
    valid_i         = 1'b1;
    pc_i            = 32'h0000_1000 + (32'(idx) << 2);
    instr_i         = r.instr;
    rs1_value_i     = lcg_next();
    rs2_value_i     = lcg_next();
    ex_reg_addr_i   = r.ex_reg_addr;
    ex_reg_wdata_i  = lcg_next();
    ex_data_addr_i  = lcg_next();
    ex_data_wdata_i = lcg_next();
    ex_data_rdata_i = lcg_next();
    // disabled fields are expected as zero
    e           = '0;
    e.pc        = pc_i;
    e.instr     = r.instr;
    e.iclass    = r.iclass;
    e.imm       = r.imm;
    {e.rd_we, e.rs1_en, e.rs2_en, e.mem_en, e.mem_we} = r.flags;
    e.rd_addr   = e.rd_we ? r.instr[11:7] : 5'd0;
    e.rd_wdata  = e.rd_we ? ex_reg_wdata_i : 32'h0;
    e.rs1_addr  = e.rs1_en ? r.instr[19:15] : 5'd0;
    e.rs1_value = e.rs1_en ? rs1_value_i : 32'h0;
    e.rs2_addr  = e.rs2_en ? r.instr[24:20] : 5'd0;
    e.rs2_value = e.rs2_en ? rs2_value_i : 32'h0;
    e.mem_addr  = e.mem_en ? ex_data_addr_i : 32'h0;
    e.mem_data  = e.mem_we ? ex_data_wdata_i : (e.mem_en ? ex_data_rdata_i : 32'h0);
    exp_rec     = e;
    exp_valid   = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // driver
  ////////////////////////////////////////////////////////////

  initial begin
    rst_ni          = 1'b0;
    fetch_enable_i  = 1'b0;
    valid_i         = 1'b0;
    pc_i            = '0;
    instr_i         = NOP_INSTR;
    rs1_value_i     = '0;
    rs2_value_i     = '0;
    ex_reg_addr_i   = '0;
    ex_reg_wdata_i  = '0;
    ex_data_addr_i  = '0;
    ex_data_wdata_i = '0;
    ex_data_rdata_i = '0;
    exp_valid       = 1'b0;
    exp_rec         = '0;
    fill_table();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // retires before fetch enable must not be traced
    repeat (2) begin
      @(negedge clk_i);
      valid_i = 1'b1;
      @(negedge clk_i);
      valid_i = 1'b0;
    end
    // the enabling edge drops its own retire
    @(negedge clk_i);
    fetch_enable_i = 1'b1;
    valid_i        = 1'b1;
    @(negedge clk_i);
    valid_i = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      repeat (rows[i].gap) begin
        @(negedge clk_i);
        valid_i   = 1'b0;
        exp_valid = 1'b0;
      end
      @(negedge clk_i);
      apply_row(i);
    end
    @(negedge clk_i);
    valid_i   = 1'b0;
    exp_valid = 1'b0;
    // drain the three-stage pipeline
    repeat (5) @(negedge clk_i);
    if (pending_cnt != 0) begin
      $display("%0d expected trace records never appeared", pending_cnt);
    end
    $display("checks done with %0d mismatches, %0d unexpected records, %0d missing records",
             mismatch_cnt, unexpected_cnt, pending_cnt);
    if (mismatch_cnt == 0 && unexpected_cnt == 0 && pending_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog allows one cycle per row and gap plus margin for reset and drain
  initial begin
    int budget;
    @(posedge rst_ni);
    budget = NUM_ROWS + 20;
    for (int i = 0; i < NUM_ROWS; i++) begin
      budget += int'(rows[i].gap);
    end
    #(budget * CLK_PERIOD);
    $display("timeout, the trace run did not finish within %0d cycles", budget);
    $display("Simulation FAILED");
    $finish;
  end

  rv_trace_top UUT (
    .clk_i, .rst_ni, .fetch_enable_i, .valid_i, .pc_i, .instr_i,
    .rs1_value_i, .rs2_value_i, .ex_reg_addr_i, .ex_reg_wdata_i,
    .ex_data_addr_i, .ex_data_wdata_i, .ex_data_rdata_i,
    .trace_valid_o, .trace_rec_o
  );

  rv_trace_checker u_checker (
    .clk_i, .rst_ni,
    .exp_valid_i      (exp_valid),
    .exp_rec_i        (exp_rec),
    .trace_valid_i    (trace_valid_o),
    .trace_rec_i      (trace_rec_o),
    .mismatch_cnt_o   (mismatch_cnt),
    .unexpected_cnt_o (unexpected_cnt),
    .pending_cnt_o    (pending_cnt)
  );

endmodule

//--- test/rv_trace_checker.sv
`timescale 1ns/1ps
// expects every record exactly three rising edges after its retire was sampled, in order
module rv_trace_checker import rv_trace_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       exp_valid_i,
  input  trace_rec_t exp_rec_i,
  input  logic       trace_valid_i,
  input  trace_rec_t trace_rec_i,
  output int         mismatch_cnt_o,
  output int         unexpected_cnt_o,
  output int         pending_cnt_o
);

  localparam int LATENCY = 3;

  trace_rec_t exp_q [$];
  cycle_t     edge_cnt;

  task automatic check_field(input string name, input word_t exp_val, input word_t act_val);
    if (exp_val !== act_val) begin
      $display("error at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
      mismatch_cnt_o++;
    end
  endtask

  task automatic compare_record(input trace_rec_t exp_rec, input trace_rec_t act_rec);
    check_field("cycle", exp_rec.cycle, act_rec.cycle);
    check_field("pc", exp_rec.pc, act_rec.pc);
    check_field("instr", exp_rec.instr, act_rec.instr);
    check_field("iclass", 32'(exp_rec.iclass), 32'(act_rec.iclass));
    check_field("imm", exp_rec.imm, act_rec.imm);
    check_field("rd_we", 32'(exp_rec.rd_we), 32'(act_rec.rd_we));
    check_field("rd_addr", 32'(exp_rec.rd_addr), 32'(act_rec.rd_addr));
    check_field("rd_wdata", exp_rec.rd_wdata, act_rec.rd_wdata);
    check_field("rs1_en", 32'(exp_rec.rs1_en), 32'(act_rec.rs1_en));
    check_field("rs1_addr", 32'(exp_rec.rs1_addr), 32'(act_rec.rs1_addr));
    check_field("rs1_value", exp_rec.rs1_value, act_rec.rs1_value);
    check_field("rs2_en", 32'(exp_rec.rs2_en), 32'(act_rec.rs2_en));
    check_field("rs2_addr", 32'(exp_rec.rs2_addr), 32'(act_rec.rs2_addr));
    check_field("rs2_value", exp_rec.rs2_value, act_rec.rs2_value);
    check_field("mem_en", 32'(exp_rec.mem_en), 32'(act_rec.mem_en));
    check_field("mem_we", 32'(exp_rec.mem_we), 32'(act_rec.mem_we));
    check_field("mem_addr", exp_rec.mem_addr, act_rec.mem_addr);
    check_field("mem_data", exp_rec.mem_data, act_rec.mem_data);
  endtask

  ////////////////////////////////////////////////////////////
  // queue and compare
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    trace_rec_t exp_rec;
    if (!rst_ni) begin
      edge_cnt         = '0;
      mismatch_cnt_o   = 0;
      unexpected_cnt_o = 0;
    end else begin
      // stamp is the counter value at the sampling edge
      if (exp_valid_i) begin
        exp_rec       = exp_rec_i;
        exp_rec.cycle = edge_cnt;
        exp_q.push_back(exp_rec);
      end
      if (trace_valid_i) begin
        if (exp_q.size() == 0) begin
          $display("unexpected trace record at %0t for pc %h while nothing was expected",
                   $time, trace_rec_i.pc);
          unexpected_cnt_o++;
        end else begin
          exp_rec = exp_q.pop_front();
          check_field("trace_valid_o cycle", exp_rec.cycle + LATENCY, edge_cnt);
          compare_record(exp_rec, trace_rec_i);
        end
      end
      edge_cnt = edge_cnt + 1;
    end
    pending_cnt_o = exp_q.size();
  end

endmodule

//--- source/rv_trace_top.sv
`timescale 1ns/1ps
// three-cycle fixed latency; every trace_valid_o strobe must be taken by the consumer
module rv_trace_top import rv_trace_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fetch_enable_i,
  input  logic       valid_i,
  input  word_t      pc_i,
  input  word_t      instr_i,
  input  word_t      rs1_value_i,
  input  word_t      rs2_value_i,
  input  reg_addr_t  ex_reg_addr_i,
  input  word_t      ex_reg_wdata_i,
  input  word_t      ex_data_addr_i,
  input  word_t      ex_data_wdata_i,
  input  word_t      ex_data_rdata_i,
  output logic       trace_valid_o,
  output trace_rec_t trace_rec_o
);

  logic         cap_valid;
  retire_rec_t  cap_rec;
  logic         dec_valid;
  decoded_rec_t dec_rec;

  ////////////////////////////////////////////////////////////
  // capture, classify, pack
  ////////////////////////////////////////////////////////////

  trace_capture u_capture (
    .clk_i, .rst_ni, .fetch_enable_i, .valid_i, .pc_i, .instr_i,
    .rs1_value_i, .rs2_value_i, .ex_reg_addr_i, .ex_reg_wdata_i,
    .ex_data_addr_i, .ex_data_wdata_i, .ex_data_rdata_i,
    .cap_valid_o (cap_valid),
    .cap_rec_o   (cap_rec)
  );

  instr_classify u_classify (
    .clk_i, .rst_ni,
    .cap_valid_i (cap_valid),
    .cap_rec_i   (cap_rec),
    .dec_valid_o (dec_valid),
    .dec_rec_o   (dec_rec)
  );

  trace_record_pack u_pack (
    .clk_i, .rst_ni,
    .dec_valid_i (dec_valid),
    .dec_rec_i   (dec_rec),
    .trace_valid_o,
    .trace_rec_o
  );

endmodule

//--- source/trace_record_pack.sv
`timescale 1ns/1ps
// a register write is reported only if the execute writeback address matches rd
module trace_record_pack import rv_trace_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         dec_valid_i,
  input  decoded_rec_t dec_rec_i,
  output logic         trace_valid_o,
  output trace_rec_t   trace_rec_o
);

  trace_rec_t rec_d;
  logic       rd_we;
  logic       rs1_en;
  logic       rs2_en;

  ////////////////////////////////////////////////////////////
  // enables
  ////////////////////////////////////////////////////////////

  assign rd_we  = dec_rec_i.writes_rd && (dec_rec_i.rd != '0) &&
                  (dec_rec_i.ret.ex_reg_addr == dec_rec_i.rd);
  // x0 sources carry nothing useful
  assign rs1_en = dec_rec_i.reads_rs1 && (dec_rec_i.rs1 != '0);
  assign rs2_en = dec_rec_i.reads_rs2 && (dec_rec_i.rs2 != '0);

  ////////////////////////////////////////////////////////////
  // record
  ////////////////////////////////////////////////////////////

  always_comb begin
    rec_d.cycle  = dec_rec_i.ret.cycle;
    rec_d.pc     = dec_rec_i.ret.pc;
    rec_d.instr  = dec_rec_i.ret.instr;
    rec_d.iclass = dec_rec_i.iclass;
    rec_d.imm    = dec_rec_i.imm;

    // disabled fields go to zero so records compare cleanly
    rec_d.rd_we     = rd_we;
    rec_d.rd_addr   = rd_we ? dec_rec_i.rd : '0;
    rec_d.rd_wdata  = rd_we ? dec_rec_i.ret.ex_reg_wdata : '0;
    rec_d.rs1_en    = rs1_en;
    rec_d.rs1_addr  = rs1_en ? dec_rec_i.rs1 : '0;
    rec_d.rs1_value = rs1_en ? dec_rec_i.ret.rs1_value : '0;
    rec_d.rs2_en    = rs2_en;
    rec_d.rs2_addr  = rs2_en ? dec_rec_i.rs2 : '0;
    rec_d.rs2_value = rs2_en ? dec_rec_i.ret.rs2_value : '0;

    rec_d.mem_en   = dec_rec_i.mem_en;
    rec_d.mem_we   = dec_rec_i.mem_en && dec_rec_i.mem_we;
    rec_d.mem_addr = dec_rec_i.mem_en ? dec_rec_i.ret.mem_addr : '0;
    if (!dec_rec_i.mem_en) begin
      rec_d.mem_data = '0;
    end else if (dec_rec_i.mem_we) begin
      // store data
      rec_d.mem_data = dec_rec_i.ret.mem_wdata;
    end else begin
      rec_d.mem_data = dec_rec_i.ret.mem_rdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_valid_o <= 1'b0;
    end else begin
      trace_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      trace_rec_o <= rec_d;
    end
  end

endmodule

//--- source/instr_classify.sv
`timescale 1ns/1ps
// RV32IM plus CSR and ecall/ebreak/mret/dret/wfi only; anything else is classed invalid
module instr_classify import rv_trace_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         cap_valid_i,
  input  retire_rec_t  cap_rec_i,
  output logic         dec_valid_o,
  output decoded_rec_t dec_rec_o
);

  word_t        instr;
  logic [6:0]   opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  instr_class_e iclass;
  word_t        imm;
  logic         writes_rd;
  logic         reads_rs1;
  logic         reads_rs2;

  assign instr  = cap_rec_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  ////////////////////////////////////////////////////////////
  // class
  ////////////////////////////////////////////////////////////

  always_comb begin
    iclass = CLS_INVALID;
    // nop first so it does not fall into addi
    if (instr == NOP_INSTR) begin
      iclass = CLS_NOP;
    end else begin
      unique case (opcode)
        OPC_LUI:    iclass = CLS_LUI;
        OPC_AUIPC:  iclass = CLS_AUIPC;
        OPC_JAL:    iclass = CLS_JAL;
        OPC_JALR:   if (funct3 == 3'b000) iclass = CLS_JALR;
        // 010 and 011 are unused branch codes
        OPC_BRANCH: if (funct3[2:1] != 2'b01) iclass = CLS_BRANCH;
        OPC_LOAD: begin
          if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) iclass = CLS_LOAD;
        end
        OPC_STORE:  if (!funct3[2] && funct3[1:0] != 2'b11) iclass = CLS_STORE;
        OPC_OPIMM: begin
          if (funct3 == 3'b001) begin
            if (funct7 == 7'b0000000) iclass = CLS_OPIMM;
          end else if (funct3 == 3'b101) begin
            // srli or srai
            if (funct7 == 7'b0000000 || funct7 == 7'b0100000) iclass = CLS_OPIMM;
          end else begin
            iclass = CLS_OPIMM;
          end
        end
        OPC_OP: begin
          if (funct7 == 7'b0000000) begin
            iclass = CLS_OP;
          end else if (funct7 == 7'b0100000) begin
            // sub and sra only
            if (funct3 == 3'b000 || funct3 == 3'b101) iclass = CLS_OP;
          end else if (funct7 == FUNCT7_MULDIV) begin
            iclass = CLS_MULDIV;
          end
        end
        OPC_SYSTEM: begin
          if (funct3 == 3'b000) begin
            // ecall, ebreak, mret, dret, wfi
            if (instr == 32'h0000_0073 || instr == 32'h0010_0073 ||
                instr == 32'h3020_0073 || instr == 32'h7b20_0073 ||
                instr == 32'h1050_0073) begin
              iclass = CLS_SYSTEM;
            end
          end else if (funct3 != 3'b100) begin
            iclass = funct3[2] ? CLS_CSR_IMM : CLS_CSR_REG;
          end
        end
        default:    iclass = CLS_INVALID;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // immediate and register use
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (iclass)
      CLS_OPIMM, CLS_LOAD, CLS_JALR: imm = {{20{instr[31]}}, instr[31:20]};
      CLS_STORE:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      CLS_BRANCH:  imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      CLS_JAL:     imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      CLS_LUI, CLS_AUIPC: imm = {instr[31:12], 12'h000};
      // csr number
      CLS_CSR_REG, CLS_CSR_IMM: imm = {20'h00000, instr[31:20]};
      default:     imm = '0;
    endcase
  end

  assign reads_rs2 = (iclass inside {CLS_OP, CLS_MULDIV, CLS_BRANCH, CLS_STORE});
  assign reads_rs1 = !(iclass inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_CSR_IMM,
                                      CLS_SYSTEM, CLS_NOP, CLS_INVALID});
  assign writes_rd = !(iclass inside {CLS_BRANCH, CLS_STORE, CLS_SYSTEM, CLS_NOP, CLS_INVALID});

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= cap_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cap_valid_i) begin
      dec_rec_o.ret       <= cap_rec_i;
      dec_rec_o.iclass    <= iclass;
      dec_rec_o.imm       <= imm;
      dec_rec_o.rd        <= instr[11:7];
      dec_rec_o.rs1       <= instr[19:15];
      dec_rec_o.rs2       <= instr[24:20];
      dec_rec_o.writes_rd <= writes_rd;
      dec_rec_o.reads_rs1 <= reads_rs1;
      dec_rec_o.reads_rs2 <= reads_rs2;
      dec_rec_o.mem_en    <= (iclass == CLS_LOAD) || (iclass == CLS_STORE);
      dec_rec_o.mem_we    <= (iclass == CLS_STORE);
    end
  end

endmodule

//--- source/trace_capture.sv
`timescale 1ns/1ps
// retires are dropped until fetch enable was seen high once after reset; no back-pressure
module trace_capture import rv_trace_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_enable_i,
  input  logic        valid_i,
  input  word_t       pc_i,
  input  word_t       instr_i,
  input  word_t       rs1_value_i,
  input  word_t       rs2_value_i,
  input  reg_addr_t   ex_reg_addr_i,
  input  word_t       ex_reg_wdata_i,
  input  word_t       ex_data_addr_i,
  input  word_t       ex_data_wdata_i,
  input  word_t       ex_data_rdata_i,
  output logic        cap_valid_o,
  output retire_rec_t cap_rec_o
);

  trace_state_e state_q;
  trace_state_e state_d;
  cycle_t       cycle_q;
  logic         sample;

  ////////////////////////////////////////////////////////////
  // enable FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      TRACE_WAIT: if (fetch_enable_i) state_d = TRACE_RUN;
      // sticky until reset
      TRACE_RUN:  state_d = TRACE_RUN;
      default:    state_d = TRACE_WAIT;
    endcase
  end

  // uses the current state, so the enabling edge itself is still ignored
  assign sample = valid_i && (state_q == TRACE_RUN);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= TRACE_WAIT;
      cycle_q     <= '0;
      cap_valid_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      cycle_q     <= cycle_q + cycle_t'(1);
      cap_valid_o <= sample;
    end
  end

  // payload only moves on a traced retire
  always_ff @(posedge clk_i) begin
    if (sample) begin
      cap_rec_o.pc           <= pc_i;
      cap_rec_o.instr        <= instr_i;
      cap_rec_o.rs1_value    <= rs1_value_i;
      cap_rec_o.rs2_value    <= rs2_value_i;
      cap_rec_o.ex_reg_addr  <= ex_reg_addr_i;
      cap_rec_o.ex_reg_wdata <= ex_reg_wdata_i;
      cap_rec_o.mem_addr     <= ex_data_addr_i;
      cap_rec_o.mem_wdata    <= ex_data_wdata_i;
      cap_rec_o.mem_rdata    <= ex_data_rdata_i;
      cap_rec_o.cycle        <= cycle_q;
    end
  end

endmodule

//--- source/rv_trace_pkg.sv
// widths fixed for RV32 with 32 registers; custom post-increment and reg-reg loads class as invalid
package rv_trace_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] cycle_t;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // RV32M lives in OP under this funct7
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  typedef enum logic {
    TRACE_WAIT,
    TRACE_RUN
  } trace_state_e;

  typedef enum logic [3:0] {
    CLS_NOP,
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_JALR,
    CLS_BRANCH,
    CLS_LOAD,
    CLS_STORE,
    CLS_OPIMM,
    CLS_OP,
    CLS_MULDIV,
    CLS_CSR_REG,
    CLS_CSR_IMM,
    CLS_SYSTEM,
    CLS_INVALID
  } instr_class_e;

  ////////////////////////////////////////////////////////////
  // stage records
  ////////////////////////////////////////////////////////////

  // retire port as sampled by capture
  typedef struct packed {
    word_t     pc;
    word_t     instr;
    word_t     rs1_value;
    word_t     rs2_value;
    reg_addr_t ex_reg_addr;
    word_t     ex_reg_wdata;
    word_t     mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;
    cycle_t    cycle;
  } retire_rec_t;

  typedef struct packed {
    retire_rec_t  ret;
    instr_class_e iclass;
    word_t        imm;
    reg_addr_t    rd;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    logic         writes_rd;
    logic         reads_rs1;
    logic         reads_rs2;
    logic         mem_en;
    logic         mem_we;
  } decoded_rec_t;

  // final record with disabled fields read as zero
  typedef struct packed {
    cycle_t       cycle;
    word_t        pc;
    word_t        instr;
    instr_class_e iclass;
    word_t        imm;
    logic         rd_we;
    reg_addr_t    rd_addr;
    word_t        rd_wdata;
    logic         rs1_en;
    reg_addr_t    rs1_addr;
    word_t        rs1_value;
    logic         rs2_en;
    reg_addr_t    rs2_addr;
    word_t        rs2_value;
    logic         mem_en;
    logic         mem_we;
    word_t        mem_addr;
    word_t        mem_data;
  } trace_rec_t;

endpackage
